// ==== verilog/bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////
    localparam int addr_width = 6;
    localparam int data_width = 128;
    localparam int id_width   = 16;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [id_width-1:0]   id_t;
    typedef logic [1:0]            resp_t;

    // Write targets
    localparam addr_t addr_fifo_data  = 6'h00;
    localparam addr_t addr_fifo_flush = 6'h10;
    localparam addr_t addr_dac_mode   = 6'h20;

    // AXI response codes in use
    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    typedef enum logic [2:0] {
        wr_idle,
        wr_fifo_data,
        wr_flush_data,
        wr_dac_data,
        wr_drain_error,
        wr_wait_resp
    } wr_state_t;

    // B channel payload
    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_payload_t;

endpackage

`default_nettype wire

// ==== verilog/resp_slot.sv ====
`default_nettype none

module resp_slot #(
    parameter type payload_t = logic
) (
    input  wire      s_axi_aclk,
    input  wire      s_axi_aresetn,
    input  wire      load,
    input  payload_t load_payload,
    input  wire      ready,
    output logic     valid,
    output payload_t payload
);

    // Valid flag, set by load and cleared by the handshake
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (ready) begin
            valid <= 1'b0;
        end
    end

    // Payload held until the next load
    always_ff @(posedge s_axi_aclk) begin
        if (load) begin
            payload <= load_payload;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Producer must not overwrite a pending response
    a_no_overwrite : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        load |-> (!valid || ready));

    // Stalled response keeps its fields
    a_payload_stable : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (valid && !ready) |=> $stable(payload));

endmodule

`default_nettype wire

// ==== verilog/read_responder.sv ====
`default_nettype none

module read_responder (
    input  wire               s_axi_aclk,
    input  wire               s_axi_aresetn,
    input  wire bridge_pkg::id_t arid,
    input  wire               arvalid,
    input  wire               rready,
    output logic              arready,
    output bridge_pkg::id_t   rid,
    output bridge_pkg::data_t rdata,
    output bridge_pkg::resp_t rresp,
    output logic              rlast,
    output logic              rvalid
);

    logic r_load;

    ////////////////////////////////////////////////////////////
    // Address acceptance
    ////////////////////////////////////////////////////////////

    // One read in flight, slot must be empty
    assign arready = !rvalid;
    assign r_load  = arvalid && arready;

    // ID slot, holds rvalid and rid until rready
    resp_slot #(
        .payload_t (bridge_pkg::id_t)
    ) u_r_slot (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .load          (r_load),
        .load_payload  (arid),
        .ready         (rready),
        .valid         (rvalid),
        .payload       (rid)
    );

    ////////////////////////////////////////////////////////////
    // Constant response fields
    ////////////////////////////////////////////////////////////

    // Reads carry no data, single beat, always OKAY
    assign rdata = '0;
    assign rresp = bridge_pkg::resp_okay;
    assign rlast = 1'b1;

endmodule

`default_nettype wire

// ==== verilog/write_channel_ctrl.sv ====
`default_nettype none

module write_channel_ctrl (
    input  wire                 s_axi_aclk,
    input  wire                 s_axi_aresetn,
    input  wire bridge_pkg::addr_t awaddr,
    input  wire bridge_pkg::id_t   awid,
    input  wire                 awvalid,
    output logic                awready,
    input  wire bridge_pkg::data_t wdata,
    input  wire                 wlast,
    input  wire                 wvalid,
    output logic                wready,
    output bridge_pkg::id_t     bid,
    output bridge_pkg::resp_t   bresp,
    output logic                bvalid,
    input  wire                 bready,
    input  wire                 rto_core_full,
    output logic                rto_core_write,
    output bridge_pkg::data_t   rto_core_fifo_din,
    output logic                rto_core_flush,
    output logic                dac_mode,
    output logic                rto_core_reset
);

    bridge_pkg::wr_state_t  state;
    bridge_pkg::wr_state_t  decode_state;
    bridge_pkg::id_t        wr_id;
    bridge_pkg::b_payload_t b_load_payload;
    bridge_pkg::b_payload_t b_payload;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   b_load;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////
    assign awready = (state == bridge_pkg::wr_idle);
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    // Last beat closes the burst
    assign b_load  = w_fire && wlast;

    // FIFO beats stall on full, other targets always take data
    always_comb begin
        case (state)
            bridge_pkg::wr_fifo_data:   wready = !rto_core_full;
            bridge_pkg::wr_flush_data,
            bridge_pkg::wr_dac_data,
            bridge_pkg::wr_drain_error: wready = 1'b1;
            default:                    wready = 1'b0;
        endcase
    end

    // Address map, unknown addresses drain to the error state
    always_comb begin
        case (awaddr)
            bridge_pkg::addr_fifo_data:  decode_state = bridge_pkg::wr_fifo_data;
            bridge_pkg::addr_fifo_flush: decode_state = bridge_pkg::wr_flush_data;
            bridge_pkg::addr_dac_mode:   decode_state = bridge_pkg::wr_dac_data;
            default:                     decode_state = bridge_pkg::wr_drain_error;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= bridge_pkg::wr_idle;
        end else begin
            case (state)
                bridge_pkg::wr_idle: begin
                    if (aw_fire) begin
                        state <= decode_state;
                    end
                end
                bridge_pkg::wr_fifo_data,
                bridge_pkg::wr_flush_data,
                bridge_pkg::wr_dac_data,
                bridge_pkg::wr_drain_error: begin
                    if (b_load) begin
                        state <= bridge_pkg::wr_wait_resp;
                    end
                end
                bridge_pkg::wr_wait_resp: begin
                    // Back to idle on the B handshake
                    if (bvalid && bready) begin
                        state <= bridge_pkg::wr_idle;
                    end
                end
                default: state <= bridge_pkg::wr_idle;
            endcase
        end
    end

    // Burst ID, taken with the address
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            wr_id <= awid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Core side
    ////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rto_core_write <= 1'b0;
            rto_core_flush <= 1'b0;
            dac_mode       <= 1'b0;
        end else begin
            rto_core_write <= w_fire && (state == bridge_pkg::wr_fifo_data);
            // One pulse per flush beat with bit 0 set
            rto_core_flush <= w_fire && (state == bridge_pkg::wr_flush_data) && wdata[0];
            // Mode follows bit 0, both set and clear
            if (w_fire && (state == bridge_pkg::wr_dac_data)) begin
                dac_mode <= wdata[0];
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (w_fire && (state == bridge_pkg::wr_fifo_data)) begin
            rto_core_fifo_din <= wdata;
        end
    end

    // Core held in reset with the bus
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rto_core_reset <= 1'b1;
        end else begin
            rto_core_reset <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // B response
    ////////////////////////////////////////////////////////////
    always_comb begin
        b_load_payload.id   = wr_id;
        b_load_payload.resp = (state == bridge_pkg::wr_drain_error) ?
                              bridge_pkg::resp_slverr : bridge_pkg::resp_okay;
    end

    resp_slot #(
        .payload_t (bridge_pkg::b_payload_t)
    ) u_b_slot (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .load          (b_load),
        .load_payload  (b_load_payload),
        .ready         (bready),
        .valid         (bvalid),
        .payload       (b_payload)
    );

    assign bid   = b_payload.id;
    assign bresp = b_payload.resp;

    // Checks
    a_write_after_room : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rto_core_write |-> !$past(rto_core_full));

    // New address only once the response is gone
    a_aw_b_exclusive : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(awready && bvalid));

endmodule

`default_nettype wire

// ==== verilog/axi_fifo_bridge.sv ====
`default_nettype none

module axi_fifo_bridge (
    input  wire                    s_axi_aclk,
    input  wire                    s_axi_aresetn,

    ////////////////////////////////////////////////////////////
    // AXI write address
    ////////////////////////////////////////////////////////////
    input  wire bridge_pkg::addr_t awaddr,
    input  wire bridge_pkg::id_t   awid,
    input  wire                    awvalid,
    output wire                    awready,

    // AXI write data
    input  wire bridge_pkg::data_t wdata,
    input  wire                    wlast,
    input  wire                    wvalid,
    output wire                    wready,

    // AXI write response
    output wire bridge_pkg::id_t   bid,
    output wire bridge_pkg::resp_t bresp,
    output wire                    bvalid,
    input  wire                    bready,

    ////////////////////////////////////////////////////////////
    // AXI read
    ////////////////////////////////////////////////////////////
    // Address not decoded, every read returns zero
    input  wire bridge_pkg::addr_t araddr,
    input  wire bridge_pkg::id_t   arid,
    input  wire                    arvalid,
    output wire                    arready,

    output wire bridge_pkg::data_t rdata,
    output wire bridge_pkg::id_t   rid,
    output wire bridge_pkg::resp_t rresp,
    output wire                    rlast,
    output wire                    rvalid,
    input  wire                    rready,

    ////////////////////////////////////////////////////////////
    // Core FIFO port
    ////////////////////////////////////////////////////////////
    output wire                    rto_core_reset,
    output wire                    rto_core_flush,
    output wire                    rto_core_write,
    output wire bridge_pkg::data_t rto_core_fifo_din,
    input  wire                    rto_core_full,
    output wire                    dac_mode
);

    // Write path with address decode and core side
    write_channel_ctrl u_write_ctrl (
        .s_axi_aclk        (s_axi_aclk),
        .s_axi_aresetn     (s_axi_aresetn),
        .awaddr            (awaddr),
        .awid              (awid),
        .awvalid           (awvalid),
        .awready           (awready),
        .wdata             (wdata),
        .wlast             (wlast),
        .wvalid            (wvalid),
        .wready            (wready),
        .bid               (bid),
        .bresp             (bresp),
        .bvalid            (bvalid),
        .bready            (bready),
        .rto_core_full     (rto_core_full),
        .rto_core_write    (rto_core_write),
        .rto_core_fifo_din (rto_core_fifo_din),
        .rto_core_flush    (rto_core_flush),
        .dac_mode          (dac_mode),
        .rto_core_reset    (rto_core_reset)
    );

    // Read path, zero data single beat
    read_responder u_read_resp (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .arid          (arid),
        .arvalid       (arvalid),
        .rready        (rready),
        .arready       (arready),
        .rid           (rid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rlast         (rlast),
        .rvalid        (rvalid)
    );

endmodule

`default_nettype wire

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Words the core FIFO port should see, oldest first
bridge_pkg::data_t      fifo_expect[$];
// B responses in issue order
bridge_pkg::b_payload_t b_expect[$];
// IDs of reads in flight
bridge_pkg::id_t        r_expect[$];

// Running flush pulse total and current mode
int   flush_expect = 0;
logic dac_expect   = 1'b0;

// Only the three mapped targets answer OKAY
function automatic bridge_pkg::resp_t expected_resp(input bridge_pkg::addr_t addr);
    case (addr)
        bridge_pkg::addr_fifo_data,
        bridge_pkg::addr_fifo_flush,
        bridge_pkg::addr_dac_mode: return bridge_pkg::resp_okay;
        default:                   return bridge_pkg::resp_slverr;
    endcase
endfunction

// Mode register takes bit 0 of each DAC beat
function automatic logic expected_dac_mode(input bridge_pkg::data_t beat);
    return beat[0];
endfunction

`endif

// ==== sim/tb_axi_fifo_bridge.sv ====
`default_nettype none

module tb_axi_fifo_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 4000;

    logic s_axi_aclk, s_axi_aresetn;
    bridge_pkg::addr_t awaddr, araddr;
    bridge_pkg::id_t awid, bid, arid, rid;
    bridge_pkg::data_t wdata, rdata, rto_core_fifo_din;
    bridge_pkg::resp_t bresp, rresp;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rlast, rvalid, rready;
    logic rto_core_reset, rto_core_flush, rto_core_write, rto_core_full, dac_mode;

    integer seed = 32'hd728237c;
    int cycle_count = 0;
    int flush_count = 0;
    logic prev_full = 1'b0, prev_b_stall = 1'b0, prev_r_stall = 1'b0;
    bridge_pkg::b_payload_t prev_b;
    bridge_pkg::id_t prev_rid;
    // Beats for the next write burst
    bridge_pkg::data_t burst_data[$];

    `include "tb_model.svh"

    axi_fifo_bridge DUT (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #50 s_axi_aclk = ~s_axi_aclk;
    end

    ////////////////////////////////////////////////////////////
    // Error reporting and random helpers
    ////////////////////////////////////////////////////////////
    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input bridge_pkg::data_t exp,
                            input bridge_pkg::data_t got);
        assert (got === exp) else begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    function automatic bridge_pkg::id_t rand_id();
        logic [31:0] r;
        r = $random(seed);
        return r[bridge_pkg::id_width-1:0];
    endfunction

    function automatic bridge_pkg::data_t rand_data();
        logic [31:0] w0, w1, w2, w3;
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        return {w3, w2, w1, w0};
    endfunction

    // Run limit
    always @(posedge s_axi_aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout, the test sequence did not finish in %0d cycles", timeout_cycles);
            $display("sim failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Monitor comparing every handshake with the model
    ////////////////////////////////////////////////////////////
    always @(posedge s_axi_aclk) begin : monitor
        bridge_pkg::b_payload_t b_exp;
        if (s_axi_aresetn) begin
            if (rto_core_write) begin
                assert (!prev_full) else report_error("FIFO write issued while full");
                assert (fifo_expect.size() > 0) else report_error("unexpected FIFO write");
                check_eq("rto_core_fifo_din", fifo_expect.pop_front(), rto_core_fifo_din);
            end
            if (rto_core_flush) flush_count = flush_count + 1;
            // Stalled responses must hold
            if (prev_b_stall) begin
                assert (bvalid && bid == prev_b.id && bresp == prev_b.resp)
                    else report_error("B response changed before bready");
            end
            if (prev_r_stall) begin
                assert (rvalid && rid == prev_rid)
                    else report_error("R beat changed before rready");
            end
            if (bvalid && bready) begin
                assert (b_expect.size() > 0) else report_error("unexpected B response");
                b_exp = b_expect.pop_front();
                check_eq("bid", bridge_pkg::data_t'(b_exp.id), bridge_pkg::data_t'(bid));
                check_eq("bresp", bridge_pkg::data_t'(b_exp.resp), bridge_pkg::data_t'(bresp));
            end
            if (rvalid && rready) begin
                assert (r_expect.size() > 0) else report_error("unexpected read beat");
                check_eq("rid", bridge_pkg::data_t'(r_expect.pop_front()),
                         bridge_pkg::data_t'(rid));
                check_eq("rdata", '0, rdata);
                check_eq("rresp", bridge_pkg::data_t'(bridge_pkg::resp_okay),
                         bridge_pkg::data_t'(rresp));
                check_eq("rlast", bridge_pkg::data_t'(1'b1), bridge_pkg::data_t'(rlast));
            end
        end
        prev_full    = rto_core_full;
        prev_b_stall = s_axi_aresetn && bvalid && !bready;
        prev_r_stall = s_axi_aresetn && rvalid && !rready;
        prev_b       = {bid, bresp};
        prev_rid     = rid;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////
    task automatic fill_random(input int n);
        repeat (n) burst_data.push_back(rand_data());
    endtask

    // One AW and the beats in burst_data followed by B with a random bready delay
    task automatic write_burst(input bridge_pkg::addr_t addr, input bit stall_full);
        bridge_pkg::id_t id;
        bridge_pkg::data_t beat;
        int nbeats;
        logic taken;
        id = rand_id();
        nbeats = burst_data.size();
        b_expect.push_back({id, expected_resp(addr)});
        @(negedge s_axi_aclk);
        awaddr = addr;
        awid = id;
        awvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!awready) @(posedge s_axi_aclk);
        for (int i = 0; i < nbeats; i++) begin
            beat = burst_data.pop_front();
            if (addr == bridge_pkg::addr_fifo_data) fifo_expect.push_back(beat);
            if (addr == bridge_pkg::addr_fifo_flush && beat[0]) flush_expect++;
            if (addr == bridge_pkg::addr_dac_mode) dac_expect = expected_dac_mode(beat);
            @(negedge s_axi_aclk);
            awvalid = 1'b0;
            wdata = beat;
            wlast = (i == nbeats - 1);
            wvalid = 1'b1;
            // Full toggles at random until the beat goes in
            taken = 1'b0;
            while (!taken) begin
                rto_core_full = stall_full && (rand_below(2) == 0);
                @(posedge s_axi_aclk);
                // Only FIFO beats wait for room
                check_eq("wready",
                         bridge_pkg::data_t'(addr != bridge_pkg::addr_fifo_data || !rto_core_full),
                         bridge_pkg::data_t'(wready));
                taken = wready;
                if (!taken) @(negedge s_axi_aclk);
            end
        end
        @(negedge s_axi_aclk);
        wvalid = 1'b0;
        wlast = 1'b0;
        rto_core_full = 1'b0;
        @(posedge s_axi_aclk);
        assert (bvalid) else report_error("bvalid did not rise one cycle after the last beat");
        repeat (rand_below(4)) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        bready = 1'b1;
        @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        bready = 1'b0;
        @(posedge s_axi_aclk);
        assert (awready) else report_error("awready did not return after the B handshake");
        @(negedge s_axi_aclk);
        check_eq("dac_mode", bridge_pkg::data_t'(dac_expect), bridge_pkg::data_t'(dac_mode));
        check_eq("rto_core_flush count", bridge_pkg::data_t'(flush_expect),
                 bridge_pkg::data_t'(flush_count));
    endtask

    task automatic read_one();
        bridge_pkg::id_t id;
        id = rand_id();
        r_expect.push_back(id);
        @(negedge s_axi_aclk);
        arid = id;
        araddr = bridge_pkg::addr_t'(rand_below(64));
        arvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!arready) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        arvalid = 1'b0;
        @(posedge s_axi_aclk);
        assert (rvalid) else report_error("rvalid did not rise one cycle after the AR handshake");
        repeat (rand_below(5)) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        rready = 1'b1;
        @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        rready = 1'b0;
        @(posedge s_axi_aclk);
        assert (!rvalid) else report_error("second read beat without a new AR");
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        bridge_pkg::data_t d;
        s_axi_aresetn = 1'b0;
        {awaddr, awid, awvalid, wdata, wlast, wvalid, bready} = '0;
        {araddr, arid, arvalid, rready, rto_core_full} = '0;
        repeat (4) @(negedge s_axi_aclk);
        check_eq("rto_core_reset", 1, bridge_pkg::data_t'(rto_core_reset));
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);
        check_eq("rto_core_reset", 0, bridge_pkg::data_t'(rto_core_reset));
        check_eq("dac_mode", 0, bridge_pkg::data_t'(dac_mode));
        check_eq("bvalid", 0, bridge_pkg::data_t'(bvalid));
        check_eq("rvalid", 0, bridge_pkg::data_t'(rvalid));
        check_eq("awready", 1, bridge_pkg::data_t'(awready));
        check_eq("arready", 1, bridge_pkg::data_t'(arready));
        // Plain FIFO bursts before bursts with full stretches
        repeat (16) begin
            fill_random(1 + rand_below(8));
            write_burst(bridge_pkg::addr_fifo_data, 1'b0);
        end
        repeat (10) begin
            fill_random(1 + rand_below(8));
            write_burst(bridge_pkg::addr_fifo_data, 1'b1);
        end
        // Flush beats with a mix of bit 0
        repeat (3) begin
            fill_random(1 + rand_below(6));
            write_burst(bridge_pkg::addr_fifo_flush, 1'b0);
        end
        // DAC mode set and then cleared
        d = rand_data();
        d[0] = 1'b1;
        burst_data.push_back(d);
        write_burst(bridge_pkg::addr_dac_mode, 1'b0);
        d[0] = 1'b0;
        burst_data.push_back(d);
        write_burst(bridge_pkg::addr_dac_mode, 1'b0);
        // Unknown address with bit 0 set on every beat to expose a flush or mode leak
        repeat (3) begin
            d = rand_data();
            d[0] = 1'b1;
            burst_data.push_back(d);
        end
        write_burst(6'h30, 1'b0);
        repeat (12) read_one();
        assert (fifo_expect.size() == 0 && b_expect.size() == 0 && r_expect.size() == 0)
            else report_error("expected transfers never appeared");
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+sim
verilog/bridge_pkg.sv
verilog/resp_slot.sv
verilog/read_responder.sv
verilog/write_channel_ctrl.sv
verilog/axi_fifo_bridge.sv
sim/tb_axi_fifo_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_fifo_bridge -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_axi_fifo_bridge 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "sim passed"; then
    exit 0
fi
echo "Pass message not found"
exit 1
